// File: pad_params.svh
/*
 * Pad counts and register byte offsets for the pad subsystem.
 * Included by the packages and by every module that sizes pads or decodes offsets.
 */
`ifndef PAD_PARAMS_SVH
`define PAD_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad counts
`define PAD_NUM_GPIO 8
`define PAD_NUM_CS   2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map, byte offsets inside the window
`define PAD_ADDR_W       4
`define PAD_REG_GPIO_OUT 4'h0
`define PAD_REG_GPIO_OE  4'h4
`define PAD_REG_MODE     4'h8
`define PAD_REG_GPIO_IN  4'hC  // Read only.

`endif

// File: pad_cfg_pkg.sv
/*
 * Pad-side types: mode word, register write data and the control bundle
 * that the register bank hands to the pad ring.
 */
`include "pad_params.svh"

package pad_cfg_pkg;

  typedef struct packed {
    logic        spi_en;   // SPI host pads.
    logic        i2c_en;   // I2C open-drain pads.
    logic        uart_en;  // UART tx pad.
    logic [28:0] rsvd;
  } pad_mode_t;

  // One write word, decoded per target register.
  typedef union packed {
    logic [31:0] raw;   // GPIO registers.
    pad_mode_t   mode;  // Mode register.
  } reg_wdata_u;

  typedef struct packed {
    logic [`PAD_NUM_GPIO-1:0] gpio_out;
    logic [`PAD_NUM_GPIO-1:0] gpio_oe;
    logic                     spi_sck_out;
    logic                     spi_sck_oe;
    logic [`PAD_NUM_CS-1:0]   spi_csb_out;
    logic [`PAD_NUM_CS-1:0]   spi_csb_oe;
    logic [3:0]               spi_sd_out;
    logic [3:0]               spi_sd_oe;
    logic                     i2c_scl_oe;  // Pad pulls low when set.
    logic                     i2c_sda_oe;
    logic                     uart_tx_out;
    logic                     uart_tx_oe;
  } pad_ctrl_t;

  typedef struct packed {
    logic                    wr;
    logic                    rd;
    logic [`PAD_ADDR_W-3:0]  addr;  // Word address.
    reg_wdata_u              wdata;
  } reg_op_t;

endpackage

// File: axil_pkg.sv
/*
 * AXI4-Lite channel bundles and response codes for the register port.
 */
package axil_pkg;

  typedef enum logic [1:0] {
    AXIL_RESP_OKAY   = 2'b00,
    AXIL_RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Master-driven half of the bus.
  typedef struct packed {
    logic        aw_valid;
    logic [31:0] aw_addr;
    logic        w_valid;
    logic [31:0] w_data;
    logic        b_ready;
    logic        ar_valid;
    logic [31:0] ar_addr;
    logic        r_ready;
  } axil_req_t;

  // Slave-driven half.
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    axil_resp_e  b_resp;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    axil_resp_e  r_resp;
  } axil_rsp_t;

endpackage

// File: axil_reg_decode.sv
/*
 * AXI4-Lite slave front end. Accepts one write and one read at a time and
 * turns them into single-cycle register strobes with OKAY/SLVERR responses.
 */
`include "pad_params.svh"

module axil_reg_decode (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  axil_pkg::axil_req_t  axil_req_i,
  output axil_pkg::axil_rsp_t  axil_rsp_o,
  output pad_cfg_pkg::reg_op_t reg_op_o,
  input  logic [31:0]          rdata_i,
  output logic                 addr_err_o
);
  import axil_pkg::*;

  logic       bvalid_q, rvalid_q;
  axil_resp_e bresp_q, rresp_q;
  logic [31:0] rdata_q;
  logic       wr_acc, rd_acc;
  logic       wr_err, rd_err;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Acceptance and offset checks
  assign wr_acc = axil_req_i.aw_valid & axil_req_i.w_valid & ~bvalid_q;
  assign rd_acc = axil_req_i.ar_valid & ~rvalid_q;

  assign wr_err = (axil_req_i.aw_addr[31:`PAD_ADDR_W] != '0) ||
                  (axil_req_i.aw_addr[1:0] != 2'b00) ||
                  (axil_req_i.aw_addr[`PAD_ADDR_W-1:0] == `PAD_REG_GPIO_IN);  // RO register.
  assign rd_err = (axil_req_i.ar_addr[31:`PAD_ADDR_W] != '0) ||
                  (axil_req_i.ar_addr[1:0] != 2'b00);

  assign addr_err_o = (wr_acc & wr_err) | (rd_acc & rd_err);

  assign reg_op_o.wr         = wr_acc & ~wr_err;  // Bad writes change nothing.
  assign reg_op_o.rd         = rd_acc & ~rd_err;
  assign reg_op_o.addr       = wr_acc ? axil_req_i.aw_addr[`PAD_ADDR_W-1:2]
                                      : axil_req_i.ar_addr[`PAD_ADDR_W-1:2];
  assign reg_op_o.wdata.raw  = axil_req_i.w_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response channels
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_acc) bvalid_q <= 1'b1;
      else if (axil_req_i.b_ready) bvalid_q <= 1'b0;
      if (rd_acc) rvalid_q <= 1'b1;
      else if (axil_req_i.r_ready) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) bresp_q <= wr_err ? AXIL_RESP_SLVERR : AXIL_RESP_OKAY;
    if (rd_acc) begin
      rresp_q <= rd_err ? AXIL_RESP_SLVERR : AXIL_RESP_OKAY;
      rdata_q <= rd_err ? 32'h0 : rdata_i;  // Unmapped reads return zero.
    end
  end

  assign axil_rsp_o.aw_ready = wr_acc;  // AW and W taken together.
  assign axil_rsp_o.w_ready  = wr_acc;
  assign axil_rsp_o.b_valid  = bvalid_q;
  assign axil_rsp_o.b_resp   = bresp_q;
  assign axil_rsp_o.ar_ready = rd_acc;
  assign axil_rsp_o.r_valid  = rvalid_q;
  assign axil_rsp_o.r_data   = rdata_q;
  assign axil_rsp_o.r_resp   = rresp_q;

  // A write response waits for the master and does not change while it waits.
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bvalid_q && !axil_req_i.b_ready) |=> (bvalid_q && $stable(bresp_q)))
    else $error("b_valid dropped or b_resp changed before b_ready");

endmodule

// File: pad_ctrl_regs.sv
/*
 * Writable pad registers (GPIO out, GPIO enable, mode) and the pad control
 * bundle built from them and the peripheral pin signals.
 */
`include "pad_params.svh"

module pad_ctrl_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  pad_cfg_pkg::reg_op_t     reg_op_i,
  input  logic                     spi_sck_i,
  input  logic                     spi_sck_en_i,
  input  logic [`PAD_NUM_CS-1:0]   spi_csb_i,
  input  logic [`PAD_NUM_CS-1:0]   spi_csb_oe_i,
  input  logic [3:0]               spi_sd_i,
  input  logic [3:0]               spi_sd_oe_i,
  input  logic                     i2c_scl_oe_i,
  input  logic                     i2c_sda_oe_i,
  input  logic                     uart_tx_i,
  output pad_cfg_pkg::pad_ctrl_t   pad_ctrl_o,
  output logic [`PAD_NUM_GPIO-1:0] gpio_out_q_o,
  output logic [`PAD_NUM_GPIO-1:0] gpio_oe_q_o,
  output pad_cfg_pkg::pad_mode_t   mode_q_o
);
  import pad_cfg_pkg::*;

  logic [`PAD_NUM_GPIO-1:0] gpio_out_q;
  logic [`PAD_NUM_GPIO-1:0] gpio_oe_q;
  pad_mode_t                mode_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register writes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;  // All pads released.
      mode_q     <= '0;
    end else if (reg_op_i.wr) begin
      case ({reg_op_i.addr, 2'b00})
        `PAD_REG_GPIO_OUT: gpio_out_q <= reg_op_i.wdata.raw[`PAD_NUM_GPIO-1:0];
        `PAD_REG_GPIO_OE:  gpio_oe_q  <= reg_op_i.wdata.raw[`PAD_NUM_GPIO-1:0];
        `PAD_REG_MODE: begin
          mode_q.spi_en  <= reg_op_i.wdata.mode.spi_en;
          mode_q.i2c_en  <= reg_op_i.wdata.mode.i2c_en;
          mode_q.uart_en <= reg_op_i.wdata.mode.uart_en;
          mode_q.rsvd    <= '0;  // Reserved bits read as zero.
        end
        default: ;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pad control, peripheral enables gated by the mode bits
  always_comb begin
    pad_ctrl_o.gpio_out    = gpio_out_q;
    pad_ctrl_o.gpio_oe     = gpio_oe_q;
    pad_ctrl_o.spi_sck_out = spi_sck_i;
    pad_ctrl_o.spi_sck_oe  = spi_sck_en_i & mode_q.spi_en;
    pad_ctrl_o.spi_csb_out = spi_csb_i;
    pad_ctrl_o.spi_csb_oe  = spi_csb_oe_i & {`PAD_NUM_CS{mode_q.spi_en}};
    pad_ctrl_o.spi_sd_out  = spi_sd_i;
    pad_ctrl_o.spi_sd_oe   = spi_sd_oe_i & {4{mode_q.spi_en}};
    pad_ctrl_o.i2c_scl_oe  = i2c_scl_oe_i & mode_q.i2c_en;
    pad_ctrl_o.i2c_sda_oe  = i2c_sda_oe_i & mode_q.i2c_en;
    pad_ctrl_o.uart_tx_out = uart_tx_i;
    pad_ctrl_o.uart_tx_oe  = mode_q.uart_en;  // Tx idles high, always driven.
  end

  assign gpio_out_q_o = gpio_out_q;
  assign gpio_oe_q_o  = gpio_oe_q;
  assign mode_q_o     = mode_q;

endmodule

// File: pad_in_sync.sv
/*
 * Brings the GPIO pin levels into the clock domain and answers register
 * reads with the selected register or the synchronized input word.
 */
`include "pad_params.svh"

module pad_in_sync (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`PAD_NUM_GPIO-1:0] gpio_raw_i,
  input  logic [`PAD_NUM_GPIO-1:0] gpio_out_q_i,
  input  logic [`PAD_NUM_GPIO-1:0] gpio_oe_q_i,
  input  pad_cfg_pkg::pad_mode_t   mode_q_i,
  input  logic [`PAD_ADDR_W-3:0]   rd_addr_i,
  output logic [`PAD_NUM_GPIO-1:0] gpio_in_o,
  output logic [31:0]              rdata_o
);

  logic [`PAD_NUM_GPIO-1:0] meta_q;
  logic [`PAD_NUM_GPIO-1:0] sync_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Two-flop synchronizer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gpio_raw_i;  // May go metastable.
      sync_q <= meta_q;
    end
  end

  assign gpio_in_o = sync_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read-back multiplexer
  always_comb begin
    case ({rd_addr_i, 2'b00})
      `PAD_REG_GPIO_OUT: rdata_o = 32'(gpio_out_q_i);
      `PAD_REG_GPIO_OE:  rdata_o = 32'(gpio_oe_q_i);
      `PAD_REG_MODE:     rdata_o = mode_q_i;
      `PAD_REG_GPIO_IN:  rdata_o = 32'(sync_q);
      default:           rdata_o = 32'h0;
    endcase
  end

endmodule

// File: pad_ring.sv
/*
 * Pad cells for every chip pin. Output pads are tristate drivers steered by
 * the pad control bundle; input-only pads just buffer the pin.
 */
`include "pad_params.svh"

module pad_ring (
  input  pad_cfg_pkg::pad_ctrl_t   pad_ctrl_i,
  // Chip pins.
  inout  logic [`PAD_NUM_GPIO-1:0] gpio_io,
  inout  logic                     spi_sck_o,
  inout  logic [`PAD_NUM_CS-1:0]   spi_csb_o,
  inout  logic [3:0]               spi_sd_io,
  inout  logic                     i2c_scl_io,
  inout  logic                     i2c_sda_io,
  inout  logic                     uart_tx_o,
  inout  logic                     uart_rx_i,
  inout  logic                     boot_select_i,
  inout  logic                     jtag_tck_i,
  inout  logic                     jtag_tms_i,
  inout  logic                     jtag_trst_ni,
  inout  logic                     jtag_tdi_i,
  inout  logic                     jtag_tdo_o,
  // Core side.
  output logic [`PAD_NUM_GPIO-1:0] gpio_raw_o,
  output logic [3:0]               spi_sd_o,
  output logic                     i2c_scl_o,
  output logic                     i2c_sda_o,
  output logic                     uart_rx_o,
  output logic                     boot_select_o,
  output logic                     jtag_tck_o,
  output logic                     jtag_tms_o,
  output logic                     jtag_trst_no,
  output logic                     jtag_tdi_o,
  input  logic                     jtag_tdo_i
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bidirectional and output pads
  for (genvar g = 0; g < `PAD_NUM_GPIO; g++) begin : g_gpio
    assign gpio_io[g]    = pad_ctrl_i.gpio_oe[g] ? pad_ctrl_i.gpio_out[g] : 1'bz;
    assign gpio_raw_o[g] = gpio_io[g];
  end

  for (genvar c = 0; c < `PAD_NUM_CS; c++) begin : g_csb
    assign spi_csb_o[c] = pad_ctrl_i.spi_csb_oe[c] ? pad_ctrl_i.spi_csb_out[c] : 1'bz;
  end

  for (genvar d = 0; d < 4; d++) begin : g_sd
    assign spi_sd_io[d] = pad_ctrl_i.spi_sd_oe[d] ? pad_ctrl_i.spi_sd_out[d] : 1'bz;
    assign spi_sd_o[d]  = spi_sd_io[d];
  end

  assign spi_sck_o = pad_ctrl_i.spi_sck_oe ? pad_ctrl_i.spi_sck_out : 1'bz;
  assign uart_tx_o = pad_ctrl_i.uart_tx_oe ? pad_ctrl_i.uart_tx_out : 1'bz;

  // Open drain, pull low or release.
  assign i2c_scl_io = pad_ctrl_i.i2c_scl_oe ? 1'b0 : 1'bz;
  assign i2c_sda_io = pad_ctrl_i.i2c_sda_oe ? 1'b0 : 1'bz;
  assign i2c_scl_o  = i2c_scl_io;
  assign i2c_sda_o  = i2c_sda_io;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input-only pads and TDO
  assign uart_rx_o     = uart_rx_i;
  assign boot_select_o = boot_select_i;
  assign jtag_tck_o    = jtag_tck_i;
  assign jtag_tms_o    = jtag_tms_i;
  assign jtag_trst_no  = jtag_trst_ni;
  assign jtag_tdi_o    = jtag_tdi_i;
  assign jtag_tdo_o    = jtag_tdo_i;  // Always driven.

endmodule

// File: pad_subsys_top.sv
/*
 * Pad subsystem top: AXI4-Lite register port, pad control registers,
 * input synchronizer and the pad ring between chip pins and peripherals.
 */
`include "pad_params.svh"

module pad_subsys_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  axil_pkg::axil_req_t      axil_req_i,
  output axil_pkg::axil_rsp_t      axil_rsp_o,
  // Chip pins.
  inout  logic [`PAD_NUM_GPIO-1:0] gpio_io,
  inout  logic                     spi_sck_o,
  inout  logic [`PAD_NUM_CS-1:0]   spi_csb_o,
  inout  logic [3:0]               spi_sd_io,
  inout  logic                     i2c_scl_io,
  inout  logic                     i2c_sda_io,
  inout  logic                     uart_tx_o,
  inout  logic                     uart_rx_i,
  inout  logic                     boot_select_i,
  inout  logic                     jtag_tck_i,
  inout  logic                     jtag_tms_i,
  inout  logic                     jtag_trst_ni,
  inout  logic                     jtag_tdi_i,
  inout  logic                     jtag_tdo_o,
  // Peripheral side.
  input  logic                     spi_sck_i,
  input  logic                     spi_sck_en_i,
  input  logic [`PAD_NUM_CS-1:0]   spi_csb_i,
  input  logic [`PAD_NUM_CS-1:0]   spi_csb_oe_i,
  input  logic [3:0]               spi_sd_i,
  input  logic [3:0]               spi_sd_oe_i,
  output logic [3:0]               spi_sd_o,
  input  logic                     i2c_scl_oe_i,
  input  logic                     i2c_sda_oe_i,
  output logic                     i2c_scl_o,
  output logic                     i2c_sda_o,
  input  logic                     uart_tx_i,
  output logic                     uart_rx_o,
  output logic                     boot_select_o,
  output logic                     jtag_tck_o,
  output logic                     jtag_tms_o,
  output logic                     jtag_trst_no,
  output logic                     jtag_tdi_o,
  input  logic                     jtag_tdo_i,
  output logic [`PAD_NUM_GPIO-1:0] gpio_in_o
);
  import pad_cfg_pkg::*;

  reg_op_t                  reg_op;
  pad_ctrl_t                pad_ctrl;
  pad_mode_t                mode_q;
  logic [`PAD_NUM_GPIO-1:0] gpio_out_q, gpio_oe_q, gpio_raw;
  logic [31:0]              rdata;
  logic                     addr_err;

  axil_reg_decode u_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .reg_op_o   (reg_op),
    .rdata_i    (rdata),
    .addr_err_o (addr_err)
  );

  pad_ctrl_regs u_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_op_i     (reg_op),
    .spi_sck_i    (spi_sck_i),
    .spi_sck_en_i (spi_sck_en_i),
    .spi_csb_i    (spi_csb_i),
    .spi_csb_oe_i (spi_csb_oe_i),
    .spi_sd_i     (spi_sd_i),
    .spi_sd_oe_i  (spi_sd_oe_i),
    .i2c_scl_oe_i (i2c_scl_oe_i),
    .i2c_sda_oe_i (i2c_sda_oe_i),
    .uart_tx_i    (uart_tx_i),
    .pad_ctrl_o   (pad_ctrl),
    .gpio_out_q_o (gpio_out_q),
    .gpio_oe_q_o  (gpio_oe_q),
    .mode_q_o     (mode_q)
  );

  pad_in_sync u_sync (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .gpio_raw_i   (gpio_raw),
    .gpio_out_q_i (gpio_out_q),
    .gpio_oe_q_i  (gpio_oe_q),
    .mode_q_i     (mode_q),
    .rd_addr_i    (axil_req_i.ar_addr[`PAD_ADDR_W-1:2]),  // Read path has its own address.
    .gpio_in_o    (gpio_in_o),
    .rdata_o      (rdata)
  );

  pad_ring u_ring (
    .pad_ctrl_i    (pad_ctrl),
    .gpio_io       (gpio_io),
    .spi_sck_o     (spi_sck_o),
    .spi_csb_o     (spi_csb_o),
    .spi_sd_io     (spi_sd_io),
    .i2c_scl_io    (i2c_scl_io),
    .i2c_sda_io    (i2c_sda_io),
    .uart_tx_o     (uart_tx_o),
    .uart_rx_i     (uart_rx_i),
    .boot_select_i (boot_select_i),
    .jtag_tck_i    (jtag_tck_i),
    .jtag_tms_i    (jtag_tms_i),
    .jtag_trst_ni  (jtag_trst_ni),
    .jtag_tdi_i    (jtag_tdi_i),
    .jtag_tdo_o    (jtag_tdo_o),
    .gpio_raw_o    (gpio_raw),
    .spi_sd_o      (spi_sd_o),
    .i2c_scl_o     (i2c_scl_o),
    .i2c_sda_o     (i2c_sda_o),
    .uart_rx_o     (uart_rx_o),
    .boot_select_o (boot_select_o),
    .jtag_tck_o    (jtag_tck_o),
    .jtag_tms_o    (jtag_tms_o),
    .jtag_trst_no  (jtag_trst_no),
    .jtag_tdi_o    (jtag_tdi_o),
    .jtag_tdo_i    (jtag_tdo_i)
  );

  // A rejected write leaves every writable register as it was.
  a_err_no_change: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (addr_err && !axil_rsp_o.ar_ready) |=>
      ($stable(gpio_out_q) && $stable(gpio_oe_q) && $stable(mode_q)))
    else $error("Register changed after a rejected write");

endmodule

// File: tb_pad_subsys.sv
/*
 * Testbench for the pad subsystem. A table of AXI4-Lite accesses, pin and
 * peripheral settings and pad checks is applied in a loop against the DUT.
 */
`include "pad_params.svh"

module tb_pad_subsys;
  import axil_pkg::*;

  localparam int          CLK_PERIOD = 100;
  localparam logic [31:0] A_OUT      = 32'(`PAD_REG_GPIO_OUT);
  localparam logic [31:0] A_OE       = 32'(`PAD_REG_GPIO_OE);
  localparam logic [31:0] A_MODE     = 32'(`PAD_REG_MODE);
  localparam logic [31:0] A_IN       = 32'(`PAD_REG_GPIO_IN);
  localparam logic [31:0] ALL_FLOAT  = 32'h0003_FFFF;  // Every controlled pad released.

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_PINS, OP_PERIPH, OP_PADS, OP_WR_HOLD,
                            OP_RD_HOLD} op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;  // Pin enables, or the undriven mask for OP_PADS.
    logic [31:0] data;
    axil_resp_e  resp;
    logic [31:0] exp;   // Read data or pad levels.
  } entry_t;

  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_oe;
    logic [3:0] sd;
    logic [3:0] sd_oe;
    logic       scl_oe;
    logic       sda_oe;
    logic       uart_tx;
  } periph_t;

  logic        clk;
  logic        rst_n;
  axil_req_t   req;
  axil_rsp_t   rsp;
  periph_t     periph;
  logic [7:0]  gpio_ext, gpio_ext_en;
  logic [5:0]  in_vals;
  logic        tdo_val;
  logic [31:0] lfsr_q;
  entry_t      tbl[$];
  int unsigned cycles, cycle_limit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pins and pin models
  wire [7:0]  gpio_io;
  wire        spi_sck, i2c_scl, i2c_sda, uart_tx, jtag_tdo;
  wire [1:0]  spi_csb;
  wire [3:0]  spi_sd;
  wire [5:0]  in_pad;
  wire [7:0]  gpio_float;
  wire [1:0]  csb_float;
  wire [3:0]  sd_float;
  wire [17:0] pad_float, pad_level;
  logic [3:0] spi_sd_core;
  logic [7:0] gpio_in;
  logic       i2c_scl_core, i2c_sda_core, uart_rx_core, boot_core;
  logic       tck_core, tms_core, trst_n_core, tdi_core;

  for (genvar g = 0; g < `PAD_NUM_GPIO; g++) begin : g_gpio_pin
    assign gpio_io[g]    = gpio_ext_en[g] ? gpio_ext[g] : 1'bz;  // External driver.
    assign gpio_float[g] = (gpio_io[g] === 1'bz);
  end
  for (genvar c = 0; c < `PAD_NUM_CS; c++) begin : g_csb_pin
    assign csb_float[c] = (spi_csb[c] === 1'bz);
  end
  for (genvar d = 0; d < 4; d++) begin : g_sd_pin
    assign sd_float[d] = (spi_sd[d] === 1'bz);
  end

  assign in_pad    = in_vals;
  assign pad_float = {gpio_float, spi_sck === 1'bz, csb_float, sd_float,
                      i2c_scl === 1'bz, i2c_sda === 1'bz, uart_tx === 1'bz};
  assign pad_level = {gpio_io, spi_sck, spi_csb, spi_sd, i2c_scl, i2c_sda, uart_tx};

  pad_subsys_top uut (
    .clk_i (clk), .rst_n_i (rst_n), .axil_req_i (req), .axil_rsp_o (rsp),
    .gpio_io (gpio_io), .spi_sck_o (spi_sck), .spi_csb_o (spi_csb), .spi_sd_io (spi_sd),
    .i2c_scl_io (i2c_scl), .i2c_sda_io (i2c_sda), .uart_tx_o (uart_tx),
    .uart_rx_i (in_pad[5]), .boot_select_i (in_pad[4]), .jtag_tck_i (in_pad[3]),
    .jtag_tms_i (in_pad[2]), .jtag_trst_ni (in_pad[1]), .jtag_tdi_i (in_pad[0]),
    .jtag_tdo_o (jtag_tdo),
    .spi_sck_i (periph.sck), .spi_sck_en_i (periph.sck_en), .spi_csb_i (periph.csb),
    .spi_csb_oe_i (periph.csb_oe), .spi_sd_i (periph.sd), .spi_sd_oe_i (periph.sd_oe),
    .spi_sd_o (spi_sd_core), .i2c_scl_oe_i (periph.scl_oe), .i2c_sda_oe_i (periph.sda_oe),
    .i2c_scl_o (i2c_scl_core), .i2c_sda_o (i2c_sda_core), .uart_tx_i (periph.uart_tx),
    .uart_rx_o (uart_rx_core), .boot_select_o (boot_core), .jtag_tck_o (tck_core),
    .jtag_tms_o (tms_core), .jtag_trst_no (trst_n_core), .jtag_tdi_o (tdi_core),
    .jtag_tdo_i (tdo_val), .gpio_in_o (gpio_in)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout, the test did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // Taps 32, 22, 2, 1.
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) w = {w[30:0], lfsr_bit()};
    return w;
  endfunction

  // Pad order, MSB first: gpio, sck, csb, sd, scl, sda, uart tx.
  function automatic logic [31:0] pad_vec(input logic [7:0] gpio, input logic sck,
      input logic [1:0] csb, input logic [3:0] sd, input logic scl, input logic sda,
      input logic tx);
    return {14'd0, gpio, sck, csb, sd, scl, sda, tx};
  endfunction

  function automatic void add_entry(input op_e op, input logic [31:0] addr,
      input logic [31:0] data, input axil_resp_e resp, input logic [31:0] exp);
    tbl.push_back(entry_t'{op, addr, data, resp, exp});
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got 0x%h, expected 0x%h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic check_pads(input logic [31:0] float_exp, input logic [31:0] level_exp);
    check_value("undriven pads", 32'(pad_float), float_exp);
    check_value("pad levels", 32'(pad_level & ~pad_float), level_exp & ~float_exp);
    // Core side of the SPI data and I2C pads sees the driven pin level.
    check_value("core-side SPI data and I2C",
                32'({spi_sd_core, i2c_scl_core, i2c_sda_core} & ~float_exp[6:1]),
                32'(level_exp[6:1] & ~float_exp[6:1]));
    check_value("input-only pads", {25'd0, uart_rx_core, boot_core, tck_core, tms_core,
                trst_n_core, tdi_core, jtag_tdo}, {25'd0, in_vals, tdo_val});
  endtask

  task automatic drive_pins(input logic [7:0] en, input logic [7:0] val);
    @(negedge clk);
    gpio_ext_en = en;
    gpio_ext    = val;
    repeat (2) @(negedge clk);  // Two synchronizer stages.
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic hold, output axil_resp_e resp);
    logic       taken;
    axil_resp_e held_resp;
    @(negedge clk);
    req.aw_valid = 1'b1;
    req.aw_addr  = addr;
    req.w_valid  = 1'b1;
    req.w_data   = data;
    do begin
      #(CLK_PERIOD / 4);
      taken = rsp.aw_ready;
      check_value("w_ready with aw_ready", 32'(rsp.w_ready), 32'(taken));
      @(negedge clk);
    end while (!taken);
    if (hold) begin
      req.w_data = ~data;  // Second write offered while B waits.
      held_resp  = rsp.b_resp;
      repeat (3) begin
        #(CLK_PERIOD / 4);
        check_value("aw_ready while B held", 32'(rsp.aw_ready), 32'd0);
        check_value("w_ready while B held", 32'(rsp.w_ready), 32'd0);
        check_value("b_valid while B held", 32'(rsp.b_valid), 32'd1);
        check_value("b_resp while B held", 32'(rsp.b_resp), 32'(held_resp));
        @(negedge clk);
      end
    end
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    req.b_ready  = 1'b1;
    while (!rsp.b_valid) @(negedge clk);
    resp = rsp.b_resp;
    @(negedge clk);
    req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, input logic hold,
                           output logic [31:0] data, output axil_resp_e resp);
    logic        taken;
    logic [31:0] held_data;
    @(negedge clk);
    req.ar_valid = 1'b1;
    req.ar_addr  = addr;
    do begin
      #(CLK_PERIOD / 4);
      taken = rsp.ar_ready;
      @(negedge clk);
    end while (!taken);
    if (hold) begin
      req.ar_addr = addr ^ 32'h4;  // Second read offered while R waits.
      held_data   = rsp.r_data;
      repeat (3) begin
        #(CLK_PERIOD / 4);
        check_value("ar_ready while R held", 32'(rsp.ar_ready), 32'd0);
        check_value("r_valid while R held", 32'(rsp.r_valid), 32'd1);
        check_value("r_data while R held", rsp.r_data, held_data);
        @(negedge clk);
      end
    end
    req.ar_valid = 1'b0;
    req.r_ready  = 1'b1;
    while (!rsp.r_valid) @(negedge clk);
    data = rsp.r_data;
    resp = rsp.r_resp;
    @(negedge clk);
    req.r_ready = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table and main sequence
  initial begin
    logic [31:0] w_out, w_oe, pin_v, pin_v2, bad_w, rdata;
    logic [7:0]  gpio_lvl;
    periph_t     p_a, p_b;
    axil_resp_e  resp;
    entry_t      e;
    req         = '0;
    periph      = '0;
    gpio_ext    = '0;
    gpio_ext_en = '0;
    in_vals     = 6'b101101;
    tdo_val     = 1'b1;
    rst_n       = 1'b0;
    cycles      = 0;
    cycle_limit = 0;
    lfsr_q      = 32'h8bda2967;

    add_entry(OP_PADS, ALL_FLOAT, 0, AXIL_RESP_OKAY, 0);
    add_entry(OP_RD, A_OUT, 0, AXIL_RESP_OKAY, 0);
    add_entry(OP_RD, A_OE, 0, AXIL_RESP_OKAY, 0);
    add_entry(OP_RD, A_MODE, 0, AXIL_RESP_OKAY, 0);
    w_out = rand_word();
    w_oe  = rand_word();
    add_entry(OP_WR, A_OUT, w_out, AXIL_RESP_OKAY, 0);
    add_entry(OP_WR, A_OE, w_oe, AXIL_RESP_OKAY, 0);
    add_entry(OP_PADS, pad_vec(~w_oe[7:0], 1'b1, 2'b11, 4'hF, 1'b1, 1'b1, 1'b1), 0,
              AXIL_RESP_OKAY, pad_vec(w_out[7:0], 1'b0, 2'b00, 4'h0, 1'b0, 1'b0, 1'b0));
    add_entry(OP_RD, A_OUT, 0, AXIL_RESP_OKAY, {24'd0, w_out[7:0]});
    add_entry(OP_RD, A_OE, 0, AXIL_RESP_OKAY, {24'd0, w_oe[7:0]});
    // Drive only the pins the DUT leaves free.
    pin_v    = rand_word();
    gpio_lvl = (w_out[7:0] & w_oe[7:0]) | (pin_v[7:0] & ~w_oe[7:0]);
    add_entry(OP_PINS, {24'd0, ~w_oe[7:0]}, pin_v, AXIL_RESP_OKAY, 0);
    add_entry(OP_PADS, pad_vec(8'h00, 1'b1, 2'b11, 4'hF, 1'b1, 1'b1, 1'b1), 0,
              AXIL_RESP_OKAY, pad_vec(gpio_lvl, 1'b0, 2'b00, 4'h0, 1'b0, 1'b0, 1'b0));
    add_entry(OP_RD, A_IN, 0, AXIL_RESP_OKAY, {24'd0, gpio_lvl});
    pin_v2 = rand_word();
    add_entry(OP_WR, A_OE, 0, AXIL_RESP_OKAY, 0);
    add_entry(OP_PINS, 32'hFF, pin_v2, AXIL_RESP_OKAY, 0);
    add_entry(OP_RD, A_IN, 0, AXIL_RESP_OKAY, {24'd0, pin_v2[7:0]});
    add_entry(OP_PINS, 0, 0, AXIL_RESP_OKAY, 0);
    // Peripheral pads, first with the mode word zero.
    p_a = periph_t'{1'b1, 1'b1, 2'b10, 2'b11, 4'b1010, 4'hF, 1'b1, 1'b0, 1'b0};
    p_b = periph_t'{1'b0, 1'b1, 2'b01, 2'b01, 4'b0101, 4'b0011, 1'b0, 1'b1, 1'b1};
    add_entry(OP_PERIPH, 0, 32'(p_a), AXIL_RESP_OKAY, 0);
    add_entry(OP_PADS, ALL_FLOAT, 0, AXIL_RESP_OKAY, 0);
    add_entry(OP_WR, A_MODE, 32'hE000_0000, AXIL_RESP_OKAY, 0);
    add_entry(OP_RD, A_MODE, 0, AXIL_RESP_OKAY, 32'hE000_0000);
    add_entry(OP_PADS, pad_vec(8'hFF, 1'b0, 2'b00, 4'h0, 1'b0, 1'b1, 1'b0), 0,
              AXIL_RESP_OKAY, pad_vec(8'h00, 1'b1, 2'b10, 4'b1010, 1'b0, 1'b0, 1'b0));
    add_entry(OP_PERIPH, 0, 32'(p_b), AXIL_RESP_OKAY, 0);
    add_entry(OP_PADS, pad_vec(8'hFF, 1'b0, 2'b10, 4'b1100, 1'b1, 1'b0, 1'b0), 0,
              AXIL_RESP_OKAY, pad_vec(8'h00, 1'b0, 2'b01, 4'b0001, 1'b0, 1'b0, 1'b1));
    // Rejected accesses.
    bad_w = rand_word();
    add_entry(OP_WR, A_IN, bad_w, AXIL_RESP_SLVERR, 0);
    add_entry(OP_WR, 32'h10, bad_w, AXIL_RESP_SLVERR, 0);
    add_entry(OP_RD, A_OUT, 0, AXIL_RESP_OKAY, {24'd0, w_out[7:0]});
    add_entry(OP_RD, A_OE, 0, AXIL_RESP_OKAY, 0);
    add_entry(OP_RD, A_MODE, 0, AXIL_RESP_OKAY, 32'hE000_0000);
    add_entry(OP_RD, 32'h14, 0, AXIL_RESP_SLVERR, 0);
    // Held responses.
    add_entry(OP_WR_HOLD, A_OUT, bad_w, AXIL_RESP_OKAY, 0);
    add_entry(OP_RD, A_OUT, 0, AXIL_RESP_OKAY, {24'd0, bad_w[7:0]});
    add_entry(OP_RD_HOLD, A_MODE, 0, AXIL_RESP_OKAY, 32'hE000_0000);
    cycle_limit = 40 * tbl.size() + 4;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_value("valids after reset", {30'd0, rsp.b_valid, rsp.r_valid}, 32'd0);

    foreach (tbl[i]) begin
      e = tbl[i];
      case (e.op)
        OP_WR, OP_WR_HOLD: begin
          axil_write(e.addr, e.data, e.op == OP_WR_HOLD, resp);
          check_value($sformatf("entry %0d write response", i), 32'(resp), 32'(e.resp));
        end
        OP_RD, OP_RD_HOLD: begin
          axil_read(e.addr, e.op == OP_RD_HOLD, rdata, resp);
          check_value($sformatf("entry %0d read response", i), 32'(resp), 32'(e.resp));
          check_value($sformatf("entry %0d read data", i), rdata, e.exp);
          if (e.addr == A_IN)
            check_value($sformatf("entry %0d synchronized inputs", i), 32'(gpio_in), e.exp);
        end
        OP_PINS: drive_pins(e.addr[7:0], e.data[7:0]);
        OP_PERIPH: begin
          @(negedge clk);
          periph = e.data[16:0];
        end
        default: begin
          @(negedge clk);
          check_pads(e.addr, e.exp);
        end
      endcase
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
pad_cfg_pkg.sv
axil_pkg.sv
axil_reg_decode.sv
pad_ctrl_regs.sv
pad_in_sync.sv
pad_ring.sv
pad_subsys_top.sv
tb_pad_subsys.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_pad_subsys
RTL_TOP   := pad_subsys_top
FILELIST  := project.f
OBJ_DIR   := obj_dir

SRCS := $(filter %.sv,$(shell cat $(FILELIST))) pad_params.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
